// ==== logic/ru_boot_seq.sv ====
// abort is only honoured while the window is open; the chosen mode holds until rst_n, and a sensible boot_wait is at least 4
`include "ru_consts.svh"

module ru_boot_seq #(
	parameter logic [31:0] boot_wait = `RU_BOOT_WAIT_DEFAULT // window in clock_rd2 cycles
) (
	input  logic                  clock_rd2,
	input  logic                  rst_n,
	input  logic [`RU_CTRL_W-1:0] user_ctrl,
	input  logic                  core_idle,
	output ru_pkg::ru_cmd_t       boot_cmd,
	output logic                  host_mode
);

	// ============================================================
	// registers
	// ============================================================
	logic [`RU_STATE_W-1:0]  state, state_nxt;
	logic [31:0]             wait_cnt;         // boot window
	logic [`RU_STEP_W-1:0]   step_cnt;         // boot write index
	logic [`RU_SETTLE_W-1:0] settle_cnt;       // cycles spent in busy wait
	logic [`RU_CTRL_W-1:0]   ctrl_q2, ctrl_q3; // abort sync
	logic                    abort_seen;
	logic                    window_done;
	logic                    settled;
	logic [`RU_CTRL_W-1:0]   boot_ctrl;
	logic [`RU_PARAM_W-1:0]  boot_param;
	logic [`RU_DATA_W-1:0]   boot_data;

	assign abort_seen  = (ctrl_q3 == `RU_CTRL_ABORT);
	assign window_done = (wait_cnt >= boot_wait - 32'd1);
	// busy from the core shows up here a few cycles after our strobe
	assign settled     = (settle_cnt == `RU_BUSY_SETTLE);

	// host code is a level from outside, two flops before use
	always_ff @(posedge clock_rd2) begin
		if (!rst_n) begin
			ctrl_q2 <= `RU_CTRL_IDLE;
			ctrl_q3 <= `RU_CTRL_IDLE;
		end else begin
			ctrl_q2 <= user_ctrl;
			ctrl_q3 <= ctrl_q2;
		end
	end

	always_ff @(posedge clock_rd2) begin
		if (!rst_n) begin
			state      <= `RU_ST_INIT;
			wait_cnt   <= '0;
			step_cnt   <= '0;
			settle_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (state == `RU_ST_INIT) begin
				wait_cnt <= wait_cnt + 32'd1; // frozen once out of init
			end
			if (state == `RU_ST_DONE) begin
				step_cnt <= step_cnt + 1'b1; // next table row
			end
			if (state != `RU_ST_BUSY_WAIT) begin
				settle_cnt <= '0;
			end else if (!settled) begin
				settle_cnt <= settle_cnt + 1'b1;
			end
		end
	end

	// ============================================================
	// next state
	// ============================================================
	always_comb begin
		state_nxt = state;
		case (state)
			`RU_ST_INIT: begin
				if (abort_seen) begin
					state_nxt = `RU_ST_USER; // abort wins over window end
				end else if (window_done) begin
					state_nxt = `RU_ST_LOAD;
				end
			end
			`RU_ST_LOAD:      state_nxt = `RU_ST_STROBE_HI;
			`RU_ST_STROBE_HI: state_nxt = `RU_ST_STROBE_LO; // write code for one cycle
			`RU_ST_STROBE_LO: state_nxt = `RU_ST_BUSY_WAIT; // back to idle, arms next edge
			`RU_ST_BUSY_WAIT: begin
				if (settled && core_idle) begin
					state_nxt = `RU_ST_DONE;
				end
			end
			`RU_ST_DONE: begin
				if (step_cnt >= `RU_BOOT_STEPS - 3'd1) begin
					state_nxt = `RU_ST_RECONFIG; // last row written
				end else begin
					state_nxt = `RU_ST_LOAD;
				end
			end
			default: state_nxt = state; // reconfig and user hold
		endcase
	end

	// control code follows the state
	always_comb begin
		case (state)
			`RU_ST_INIT:      boot_ctrl = `RU_CTRL_RESET;
			`RU_ST_STROBE_HI: boot_ctrl = `RU_CTRL_WRITE;
			`RU_ST_RECONFIG:  boot_ctrl = `RU_CTRL_RECONFIG;
			default:          boot_ctrl = `RU_CTRL_IDLE;
		endcase
	end

	// boot table, row picked by step
	always_comb begin
		case (step_cnt)
			3'd0: begin
				boot_param = `RU_BOOT_PARAM_0;
				boot_data  = `RU_BOOT_DATA_0;
			end
			3'd1: begin
				boot_param = `RU_BOOT_PARAM_1;
				boot_data  = `RU_BOOT_DATA_1;
			end
			3'd2: begin
				boot_param = `RU_BOOT_PARAM_2;
				boot_data  = `RU_BOOT_DATA_2;
			end
			default: begin
				boot_param = `RU_BOOT_PARAM_3; // also seen while reconfig holds
				boot_data  = `RU_BOOT_DATA_3;
			end
		endcase
	end

	assign boot_cmd  = '{ctrl: boot_ctrl, param: boot_param, data: boot_data};
	assign host_mode = (state == `RU_ST_USER);

	// a load past the table end would replay row 3 and skip reconfig
	a_step_in_table : assert property (@(posedge clock_rd2) disable iff (!rst_n)
		(state == `RU_ST_LOAD) |-> (step_cnt <= 3'd3));

endmodule

// ==== logic/ru_cmd_ctrl.sv ====
// host code must pass through idle between accesses; there is no back-pressure, so the host waits on busy itself
`include "ru_consts.svh"

module ru_cmd_ctrl (
	input  logic            clock_rd2,
	input  logic            rst_n,
	input  ru_pkg::ru_cmd_t user_cmd,
	input  ru_pkg::ru_cmd_t boot_cmd,
	input  logic            host_mode,
	output ru_pkg::ru_req_t core_req
);
	import ru_pkg::*;

	ru_cmd_t                sel_cmd;            // command in charge this cycle
	logic [`RU_CTRL_W-1:0]  ctrl_q, ctrl_last;  // stage 1 and the one before
	logic [`RU_PARAM_W-1:0] param_q, param_q2;
	logic [`RU_DATA_W-1:0]  data_q, data_q2;
	logic                   reset_q;
	logic                   read_q;
	logic                   write_q;
	logic                   reconfig_q;
	logic [`RU_TIMER_W-1:0] timer_cnt;          // free running

	// boot table owns the core until the sequencer hands it over
	assign sel_cmd = host_mode ? user_cmd : boot_cmd;

	// ============================================================
	// stage 1
	// ============================================================
	always_ff @(posedge clock_rd2) begin
		if (!rst_n) begin
			ctrl_q <= `RU_CTRL_RESET; // matches the sequencer's init code
		end else begin
			ctrl_q <= sel_cmd.ctrl;
		end
	end

	always_ff @(posedge clock_rd2) begin
		param_q <= sel_cmd.param;
		data_q  <= sel_cmd.data;
	end

	// ============================================================
	// stage 2, decode against previous code
	// ============================================================
	always_ff @(posedge clock_rd2) begin
		if (!rst_n) begin
			ctrl_last  <= `RU_CTRL_RESET;
			reset_q    <= 1'b1; // core held in reset from the start
			read_q     <= 1'b0;
			write_q    <= 1'b0;
			reconfig_q <= 1'b0;
		end else begin
			ctrl_last  <= ctrl_q;
			reset_q    <= (ctrl_q == `RU_CTRL_RESET);
			read_q     <= (ctrl_q == `RU_CTRL_READ) && (ctrl_last == `RU_CTRL_IDLE);
			write_q    <= (ctrl_q == `RU_CTRL_WRITE) && (ctrl_last == `RU_CTRL_IDLE);
			reconfig_q <= (ctrl_q == `RU_CTRL_RECONFIG); // held as long as code is 7
		end
	end

	// payload lines up with the strobes
	always_ff @(posedge clock_rd2) begin
		param_q2 <= param_q;
		data_q2  <= data_q;
	end

	// watchdog kick, long high and low halves so the core sees it
	always_ff @(posedge clock_rd2) begin
		if (!rst_n) begin
			timer_cnt <= '0;
		end else begin
			timer_cnt <= timer_cnt + 1'b1;
		end
	end

	always_comb begin
		core_req.reset       = reset_q;
		core_req.read_param  = read_q;
		core_req.write_param = write_q;
		core_req.reconfig    = reconfig_q;
		core_req.reset_timer = timer_cnt[`RU_TIMER_W-1];
		core_req.param       = param_q2;
		core_req.data_in     = data_q2;
	end

	a_one_strobe : assert property (@(posedge clock_rd2) disable iff (!rst_n)
		!(core_req.read_param && core_req.write_param));

endmodule

// ==== logic/ru_consts.svh ====
// core codes and the boot table are fixed for the remote-update core and need a rebuild to change
`ifndef RU_CONSTS_SVH
`define RU_CONSTS_SVH

// ============================================================
// widths
// ============================================================
`define RU_CTRL_W   3  // host control code
`define RU_PARAM_W  3  // core parameter select
`define RU_DATA_W   32 // core data bus
`define RU_STEP_W   3  // boot step counter
`define RU_STATE_W  3  // boot sequencer state
`define RU_SETTLE_W 2  // busy round trip guard
`define RU_TIMER_W  8  // reset-timer counter

// host control codes, anything else decodes to nothing
`define RU_CTRL_IDLE     3'd0
`define RU_CTRL_READ     3'd1 // strobe on step out of idle
`define RU_CTRL_WRITE    3'd2 // strobe on step out of idle
`define RU_CTRL_RESET    3'd4 // level
`define RU_CTRL_ABORT    3'd5 // only looked at during the boot window
`define RU_CTRL_RECONFIG 3'd7 // level

// ============================================================
// boot table
// ============================================================
`define RU_BOOT_STEPS   3'd4
`define RU_BOOT_PARAM_0 3'd5 // config mode
`define RU_BOOT_PARAM_1 3'd4 // image start address
`define RU_BOOT_PARAM_2 3'd2 // watchdog timeout
`define RU_BOOT_PARAM_3 3'd3 // watchdog enable
`define RU_BOOT_DATA_0  32'h0000_0001 // application mode
`define RU_BOOT_DATA_1  32'h0200_0000 // application image in flash
`define RU_BOOT_DATA_2  32'h0000_1FFF
`define RU_BOOT_DATA_3  32'h0000_0001

`define RU_BOOT_WAIT_DEFAULT 32'd125000000 // about one second of core clock
`define RU_BUSY_SETTLE       2'd3 // strobe reg + core + busy sync latency

// boot sequencer states
`define RU_ST_INIT      3'd0 // core held in reset, window open
`define RU_ST_LOAD      3'd1
`define RU_ST_STROBE_HI 3'd2
`define RU_ST_STROBE_LO 3'd3
`define RU_ST_BUSY_WAIT 3'd4
`define RU_ST_DONE      3'd5
`define RU_ST_RECONFIG  3'd6 // final
`define RU_ST_USER      3'd7 // final, host owns the core

`endif

// ==== logic/ru_pkg.sv ====
// field order of each bundle is fixed; the testbench packs and unpacks with the same types
`include "ru_consts.svh"

package ru_pkg;

	// ============================================================
	// command into the control path
	// ============================================================
	// same shape whether it comes from the host or the boot table
	typedef struct packed {
		logic [`RU_CTRL_W-1:0]  ctrl;  // control code
		logic [`RU_PARAM_W-1:0] param; // parameter select
		logic [`RU_DATA_W-1:0]  data;  // write data
	} ru_cmd_t;

	// ============================================================
	// core side
	// ============================================================
	// request toward the remote-update core
	typedef struct packed {
		logic                   reset;       // level, active high
		logic                   read_param;  // one cycle strobe
		logic                   write_param; // one cycle strobe
		logic                   reconfig;    // level, starts reload
		logic                   reset_timer; // watchdog kick
		logic [`RU_PARAM_W-1:0] param;
		logic [`RU_DATA_W-1:0]  data_in;
	} ru_req_t;

	// response from the core
	typedef struct packed {
		logic                  busy;     // high while a param access runs
		logic [`RU_DATA_W-1:0] data_out; // valid once busy drops
	} ru_rsp_t;

endpackage

// ==== logic/ru_readback.sv ====
// core data_out must stay stable for three cycles after busy falls, and the first fall after rst_n is what gets captured
`include "ru_consts.svh"

module ru_readback (
	input  logic                  clock_rd2,
	input  logic                  rst_n,
	input  ru_pkg::ru_rsp_t       core_rsp,
	output logic [`RU_DATA_W-1:0] ru_data_out,
	output logic                  core_idle
);

	logic [2:0]            busy_sh;   // [0] newest sample
	logic                  busy_fall; // older pair shows 1 then 0
	logic [`RU_DATA_W-1:0] data_q;

	// ============================================================
	// busy sync and edge
	// ============================================================
	always_ff @(posedge clock_rd2) begin
		if (!rst_n) begin
			busy_sh <= '0;
		end else begin
			busy_sh <= {busy_sh[1:0], core_rsp.busy};
		end
	end

	assign busy_fall = (busy_sh[2:1] == 2'b10);
	assign core_idle = (busy_sh[2:1] == 2'b00); // both settled samples low

	// capture on the fall, hold until the next one
	always_ff @(posedge clock_rd2) begin
		if (!rst_n) begin
			data_q <= '0;
		end else if (busy_fall) begin
			data_q <= core_rsp.data_out;
		end
	end

	assign ru_data_out = data_q;

endmodule

// ==== logic/ru_top.sv ====
// the core runs on clock_rd2 too, and the default boot_wait is far too long for simulation
`include "ru_consts.svh"

module ru_top #(
	parameter logic [31:0] boot_wait = `RU_BOOT_WAIT_DEFAULT // cycles before auto boot
) (
	input  logic                  clock_rd2,
	input  logic                  rst_n,
	input  ru_pkg::ru_cmd_t       user_cmd, // host levels
	input  ru_pkg::ru_rsp_t       core_rsp,
	output ru_pkg::ru_req_t       core_req,
	output logic [`RU_DATA_W-1:0] ru_data_out
);
	import ru_pkg::*;

	ru_cmd_t boot_cmd;  // sequencer command
	logic    host_mode; // host owns the core
	logic    core_idle; // busy settled low

	// ============================================================
	// boot sequencer
	// ============================================================
	ru_boot_seq #(
		.boot_wait (boot_wait)
	) u_boot_seq (
		.clock_rd2 (clock_rd2),
		.rst_n     (rst_n),
		.user_ctrl (user_cmd.ctrl), // only the abort code matters here
		.core_idle (core_idle),
		.boot_cmd  (boot_cmd),
		.host_mode (host_mode)
	);

	// command select and strobe decode
	ru_cmd_ctrl u_cmd_ctrl (
		.clock_rd2 (clock_rd2),
		.rst_n     (rst_n),
		.user_cmd  (user_cmd),
		.boot_cmd  (boot_cmd),
		.host_mode (host_mode),
		.core_req  (core_req)
	);

	// read data capture
	ru_readback u_readback (
		.clock_rd2   (clock_rd2),
		.rst_n       (rst_n),
		.core_rsp    (core_rsp),
		.ru_data_out (ru_data_out),
		.core_idle   (core_idle)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of tb_ru_top, passes only when the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module tb_ru_top -o sim_ru_top &&
	./obj_dir/sim_ru_top | tee /dev/stderr | grep -qx "NO ERRORS" &&
	echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}

// ==== src.f ====
+incdir+logic
logic/ru_pkg.sv
logic/ru_boot_seq.sv
logic/ru_cmd_ctrl.sv
logic/ru_readback.sv
logic/ru_top.sv
verif/tb_ru_top.sv

// ==== verif/ru_stim.txt ====
// columns: op a b c in hex; op 0 reset, 1 drive ctrl param data, 2 idle a cycles, 3 flags a = {rst,rd,wr,rcfg}
// 4 data_out a, 5 or A write or read log a param b data c, 6 counts wr a rd b, 7 wait reconfig a timeout b, 8 core data a, 9 busy cycle timeout a, B bit a is b, F end
0 0 0 0              // boot without abort
3 8 0 0
4 0 0 0
7 1 3E8 0            // window then four writes
6 4 0 0
5 0 5 00000001
5 1 4 02000000
5 2 2 00001FFF
5 3 3 00000001
2 14 0 0
B 0 1 0              // reconfig still up
B 1 0 0
0 0 0 0              // abort inside the window
1 5 0 0
2 12C 0 0            // well past the window
6 0 0 0
3 0 0 0
1 0 0 0
8 A5A51234 0 0       // host read
1 1 6 11112222
9 64 0 0
1 0 0 0
A 0 6 11112222
4 A5A51234 0 0
1 2 1 DEADBEEF       // host write, code held
2 14 0 0
6 1 1 0
5 0 1 DEADBEEF
1 0 0 0
8 0BADF00D 0 0       // new core word, no busy fall
2 A 0 0
4 A5A51234 0 0
1 1 7 00000000
9 64 0 0
1 0 0 0
4 0BADF00D 0 0
6 1 2 0
1 4 0 0              // reset level
2 6 0 0
3 8 0 0
1 7 0 0              // reconfig level
7 1 14 0
F 0 0 0

// ==== verif/tb_ru_top.sv ====
// boot_wait is cut to 200 cycles; the core model takes one access at a time and answers each strobe with busy
`include "ru_consts.svh"

module tb_ru_top;
	import ru_pkg::*;

	localparam int STIM_WORDS = 256; // four words per stim line
	localparam int LOG_DEPTH  = 16;

	logic                  clock_rd2;
	logic                  rst_n;
	ru_cmd_t               user_cmd;
	ru_rsp_t               core_rsp;
	ru_req_t               core_req;
	logic [`RU_DATA_W-1:0] ru_data_out;

	logic [31:0]           stim [0:STIM_WORDS-1];
	ru_req_t               wr_log [0:LOG_DEPTH-1]; // strobes seen by the core model
	ru_req_t               rd_log [0:LOG_DEPTH-1];
	int                    wr_cnt;
	int                    rd_cnt;
	logic                  model_busy;
	logic [`RU_DATA_W-1:0] model_data;
	logic                  recfg_prev;
	logic                  recfg_dropped; // sticky once reconfig falls
	int unsigned           kick_cycles;   // clock_rd2 cycles since rst_n released
	ru_req_t               flag_mask;
	ru_req_t               pay_mask;
	int                    err_cnt;
	int                    chk_cnt;
	logic                  timed_out;

	assign core_rsp = '{busy: model_busy, data_out: model_data};

	ru_top #(
		.boot_wait (32'd200)
	) dut0 (
		.clock_rd2   (clock_rd2),
		.rst_n       (rst_n),
		.user_cmd    (user_cmd),
		.core_rsp    (core_rsp),
		.core_req    (core_req),
		.ru_data_out (ru_data_out)
	);

	initial begin
		clock_rd2 = 1'b0;
		forever #10 clock_rd2 = ~clock_rd2; // period 20
	end

	// ============================================================
	// compare tasks
	// ============================================================
	task automatic chk_req(input string name, input ru_req_t got, input ru_req_t exp,
		input ru_req_t mask);
		chk_cnt++;
		if ((got & mask) !== (exp & mask)) begin
			err_cnt++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got & mask, exp & mask);
		end
	endtask

	task automatic chk_word(input string name, input logic [`RU_DATA_W-1:0] got,
		input logic [`RU_DATA_W-1:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic chk_bit(input string name, input logic got, input logic exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	// flags are {reset, read, write, reconfig}
	function automatic ru_req_t make_req(input logic [3:0] flags, input logic [31:0] param,
		input logic [31:0] data);
		ru_req_t r;
		r             = '0;
		r.reset       = flags[3];
		r.read_param  = flags[2];
		r.write_param = flags[1];
		r.reconfig    = flags[0];
		r.param       = param[`RU_PARAM_W-1:0];
		r.data_in     = data;
		return r;
	endfunction

	// ============================================================
	// bounded waits
	// ============================================================
	task automatic wait_reconfig(input logic level, input int limit);
		int n;
		n = 0;
		while (core_req.reconfig !== level && n < limit) begin
			@(negedge clock_rd2);
			n++;
		end
		if (core_req.reconfig !== level) begin
			timed_out = 1'b1;
			$display("reconfig did not reach %b within %0d cycles", level, limit);
		end
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int n;
		n = 0;
		while (core_rsp.busy !== level && n < limit) begin
			@(negedge clock_rd2);
			n++;
		end
		if (core_rsp.busy !== level) begin
			timed_out = 1'b1;
			$display("core busy did not reach %b within %0d cycles", level, limit);
		end
	endtask

	task automatic apply_reset();
		@(posedge clock_rd2);
		#2;
		rst_n = 1'b0;
		repeat (8) @(posedge clock_rd2);
		#2;
		rst_n = 1'b1;
	endtask

	// ============================================================
	// core model
	// ============================================================
	initial begin : core_model
		int          blen;
		int unsigned seed_ret;
		seed_ret   = $urandom(32'he4d80030);
		model_busy = 1'b0;
		forever begin
			@(negedge clock_rd2); // req is settled here
			if (!rst_n) begin
				wr_cnt = 0;
				rd_cnt = 0;
			end else if (core_req.write_param || core_req.read_param) begin
				if (core_req.write_param && wr_cnt < LOG_DEPTH) begin
					wr_log[wr_cnt] = core_req;
					wr_cnt++;
				end
				if (core_req.read_param && rd_cnt < LOG_DEPTH) begin
					rd_log[rd_cnt] = core_req;
					rd_cnt++;
				end
				blen = 3 + int'($urandom % 6); // 3 to 8 cycles
				@(posedge clock_rd2);
				#2;
				model_busy = 1'b1;
				repeat (blen) @(posedge clock_rd2);
				#2;
				model_busy = 1'b0;
			end
		end
	end

	// reconfig must stay up once raised
	always @(negedge clock_rd2) begin
		if (!rst_n) begin
			recfg_prev    <= 1'b0;
			recfg_dropped <= 1'b0;
		end else begin
			if (recfg_prev && !core_req.reconfig) begin
				recfg_dropped <= 1'b1;
			end
			recfg_prev <= core_req.reconfig;
		end
	end

	// watchdog kick is high in the second half of every 256 cycles after reset
	always @(negedge clock_rd2) begin
		if (!rst_n) begin
			kick_cycles = 0;
		end else begin
			chk_bit("core_req.reset_timer", core_req.reset_timer, (kick_cycles % 256) >= 128);
			kick_cycles++;
		end
	end

	// ============================================================
	// stimulus from file
	// ============================================================
	initial begin : stimulus
		int          idx;
		logic [31:0] op, a, b, c;
		logic        done;
		rst_n      = 1'b0;
		user_cmd   = '0;
		model_data = '0;
		err_cnt    = 0;
		chk_cnt    = 0;
		timed_out  = 1'b0;
		done       = 1'b0;
		flag_mask  = make_req(4'hF, 32'h0, 32'h0);
		pay_mask   = make_req(4'h0, 32'h7, 32'hFFFF_FFFF); // param and data only
		$readmemh("verif/ru_stim.txt", stim);
		idx = 0;
		while (!done && !timed_out && idx < STIM_WORDS) begin
			op  = stim[idx];
			a   = stim[idx+1];
			b   = stim[idx+2];
			c   = stim[idx+3];
			idx = idx + 4;
			case (op)
				32'h0: apply_reset();
				32'h1: begin
					@(posedge clock_rd2);
					#2;
					user_cmd = '{ctrl: a[`RU_CTRL_W-1:0], param: b[`RU_PARAM_W-1:0], data: c};
				end
				32'h2: repeat (a) @(negedge clock_rd2);
				32'h3: chk_req("core_req flags", core_req, make_req(a[3:0], 0, 0), flag_mask);
				32'h4: chk_word("ru_data_out", ru_data_out, a);
				32'h5: chk_req("write strobe payload", wr_log[a[3:0]], make_req(0, b, c), pay_mask);
				32'h6: begin
					chk_word("write strobe count", wr_cnt, a);
					chk_word("read strobe count", rd_cnt, b);
				end
				32'h7: wait_reconfig(a[0], int'(b));
				32'h8: begin
					@(posedge clock_rd2);
					#2;
					model_data = a;
				end
				32'h9: begin
					wait_busy(1'b1, int'(a)); // access starts
					if (!timed_out) begin
						wait_busy(1'b0, int'(a));
					end
					if (!timed_out) begin
						repeat (4) @(negedge clock_rd2); // 3 cycle capture path
					end
				end
				32'hA: chk_req("read strobe payload", rd_log[a[3:0]], make_req(0, b, c), pay_mask);
				32'hB: begin
					if (a == 32'h0) begin
						chk_bit("core_req.reconfig", core_req.reconfig, b[0]);
					end else begin
						chk_bit("reconfig dropped", recfg_dropped, b[0]);
					end
				end
				32'hF: done = 1'b1;
				default: begin
					err_cnt++;
					$display("unknown operation %h on stimulus line %0d", op, idx / 4);
					done = 1'b1;
				end
			endcase
		end
		if (!done && !timed_out) begin
			err_cnt++;
			$display("stimulus ran out without an end operation");
		end
		$display("checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, timed_out);
		if (err_cnt == 0 && !timed_out) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
